// ==== verilog/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Instruction and program counter width
`define XLEN 32

// Register file index width
`define REG_ADDR_W 5

// Major opcodes of the RV32I subset in use
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011

// Plain integer operation
`define F7_BASE     7'b0000000

// SUB and SRA/SRAI variant
`define F7_ALT      7'b0100000

// M extension group under OP
`define F7_MULDIV   7'b0000001

`endif

// ==== verilog/decode_pkg.sv ====
`include "decode_defines.svh"

package decode_pkg;

    // Instruction word or program counter
    typedef logic [`XLEN-1:0] word_t;

    // Register file index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Commands from execute, passed back to fetch
    typedef enum logic [1:0] {
        CMD_NONE   = 2'd0,
        CMD_KILL   = 2'd1,
        CMD_FLUSH  = 2'd2,
        CMD_BRANCH = 2'd3
    } pipeline_cmd_t;

    // Instruction class seen by execute
    typedef enum logic [2:0] {
        TYPE_NOP, TYPE_ALU, TYPE_MULDIV, TYPE_JUMP,
        TYPE_BRANCH, TYPE_LOAD, TYPE_STORE
    } instr_type_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
    } alu_sel_t;

    // Order follows funct3 of the M extension
    typedef enum logic [2:0] {
        MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU,
        MD_DIV, MD_DIVU, MD_REM, MD_REMU
    } muldiv_sel_t;

    // First ALU operand
    typedef enum logic {IN0_RS1, IN0_PC} in0_sel_t;

    // Second ALU operand from rs2 or one of the immediate formats
    typedef enum logic [2:0] {
        IN1_RS2, IN1_SIMM12, IN1_IMM_UPPER,
        IN1_JAL_OFFSET, IN1_BRANCH_OFFSET, IN1_STORE_IMM
    } in1_sel_t;

    // Source of the destination register value
    typedef enum logic [1:0] {RD_ALU, RD_MULDIV, RD_LUI, RD_MEMORY} rd_sel_t;

    // Shift amount from rs2 or from the immediate field
    typedef enum logic {SHAMT_RS2, SHAMT_IMM} shamt_sel_t;

    // Stage occupancy
    typedef enum logic {STATE_EMPTY, STATE_FULL} stage_state_t;

endpackage

// ==== verilog/decode_classify.sv ====
`include "decode_defines.svh"

module decode_classify (
    input  decode_pkg::word_t       instr,
    output decode_pkg::instr_type_t instr_type,
    output decode_pkg::alu_sel_t    alu_sel,
    output decode_pkg::muldiv_sel_t muldiv_sel,
    output decode_pkg::in0_sel_t    in0_sel,
    output decode_pkg::in1_sel_t    in1_sel,
    output decode_pkg::rd_sel_t     rd_sel,
    output decode_pkg::shamt_sel_t  shamt_sel,
    output logic                    illegal,
    output logic                    uses_rs1,
    output logic                    uses_rs2
);
    import decode_pkg::*;

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    alu_sel_t   f3_alu;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt    = (funct7 == `F7_ALT);

    // ALU operation from funct3
    // SUB only exists in register form
    // ADDI ignores bit 30
    always_comb begin
        case (funct3)
            3'b000:  f3_alu = (opcode == `OPC_OP && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  f3_alu = ALU_SLL;
            3'b010:  f3_alu = ALU_SLT;
            3'b011:  f3_alu = ALU_SLTU;
            3'b100:  f3_alu = ALU_XOR;
            3'b101:  f3_alu = alt ? ALU_SRA : ALU_SRL;
            3'b110:  f3_alu = ALU_OR;
            default: f3_alu = ALU_AND;
        endcase
    end

    always_comb begin
        // Defaults that an illegal word also leaves behind
        instr_type = TYPE_NOP;
        alu_sel    = ALU_ADD;
        muldiv_sel = MD_MUL;
        in0_sel    = IN0_RS1;
        in1_sel    = IN1_RS2;
        rd_sel     = RD_ALU;
        shamt_sel  = SHAMT_RS2;
        illegal    = 1'b0;
        uses_rs1   = 1'b0;
        uses_rs2   = 1'b0;

        case (opcode)
            `OPC_OP: begin
                if (funct7 == `F7_MULDIV) begin
                    instr_type = TYPE_MULDIV;
                    // funct3 maps straight onto the enum order
                    muldiv_sel = muldiv_sel_t'(funct3);
                    rd_sel     = RD_MULDIV;
                    uses_rs1   = 1'b1;
                    uses_rs2   = 1'b1;
                end else if (funct7 == `F7_BASE ||
                             (alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    instr_type = TYPE_ALU;
                    alu_sel    = f3_alu;
                    uses_rs1   = 1'b1;
                    uses_rs2   = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            `OPC_OP_IMM: begin
                // Shift immediates constrain the upper bits
                if ((funct3 == 3'b001 && funct7 != `F7_BASE) ||
                    (funct3 == 3'b101 && funct7 != `F7_BASE && !alt)) begin
                    illegal = 1'b1;
                end else begin
                    instr_type = TYPE_ALU;
                    alu_sel    = f3_alu;
                    in1_sel    = IN1_SIMM12;
                    shamt_sel  = SHAMT_IMM;
                    uses_rs1   = 1'b1;
                end
            end
            `OPC_LUI: begin
                instr_type = TYPE_ALU;
                rd_sel     = RD_LUI;
            end
            `OPC_AUIPC: begin
                // pc plus upper immediate
                instr_type = TYPE_ALU;
                in0_sel    = IN0_PC;
                in1_sel    = IN1_IMM_UPPER;
            end
            `OPC_JAL: begin
                instr_type = TYPE_JUMP;
                in0_sel    = IN0_PC;
                in1_sel    = IN1_JAL_OFFSET;
            end
            `OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    instr_type = TYPE_JUMP;
                    in1_sel    = IN1_SIMM12;
                    uses_rs1   = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            `OPC_BRANCH: begin
                // Target is pc plus offset and execute does the compare
                instr_type = TYPE_BRANCH;
                in0_sel    = IN0_PC;
                in1_sel    = IN1_BRANCH_OFFSET;
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
            end
            `OPC_LOAD: begin
                instr_type = TYPE_LOAD;
                in1_sel    = IN1_SIMM12;
                rd_sel     = RD_MEMORY;
                uses_rs1   = 1'b1;
            end
            `OPC_STORE: begin
                // Only SB, SH and SW exist
                if (!funct3[2]) begin
                    instr_type = TYPE_STORE;
                    in1_sel    = IN1_STORE_IMM;
                    uses_rs1   = 1'b1;
                    uses_rs2   = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            // SYSTEM, FENCE, AMO and everything unknown
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== verilog/decode_ctrl.sv ====
module decode_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      f2d_instr_valid,
    input  decode_pkg::reg_addr_t     rs1_addr,
    input  decode_pkg::reg_addr_t     rs2_addr,
    input  logic                      uses_rs1,
    input  logic                      uses_rs2,
    input  logic                      e2d_ready,
    input  decode_pkg::pipeline_cmd_t e2d_cmd,
    input  logic                      e2d_rd_write,
    input  decode_pkg::reg_addr_t     e2d_rd_waddr,
    output logic                      load,
    output logic                      d2e_instr_valid,
    output logic                      d2f_ready,
    output logic                      rs1_read,
    output logic                      rs2_read
);
    import decode_pkg::*;

    stage_state_t state;
    stage_state_t state_nxt;
    logic         cmd_active;
    logic         rs1_stale;
    logic         rs2_stale;

    assign cmd_active = (e2d_cmd != CMD_NONE);

    // Source about to be overwritten by execute
    assign rs1_stale = uses_rs1 && e2d_rd_write && (rs1_addr == e2d_rd_waddr);
    assign rs2_stale = uses_rs2 && e2d_rd_write && (rs2_addr == e2d_rd_waddr);

    // Take a new instruction when the slot is free or being drained this cycle
    assign load = f2d_instr_valid && !cmd_active && !rs1_stale && !rs2_stale &&
                  (state == STATE_EMPTY || e2d_ready);

    // A command also consumes whatever fetch presents
    assign d2f_ready = load || cmd_active;

    // Register file reads only for sources actually used
    assign rs1_read = load && uses_rs1;
    assign rs2_read = load && uses_rs2;

    assign d2e_instr_valid = (state == STATE_FULL);

    always_comb begin
        if (load) begin
            state_nxt = STATE_FULL;
        end else if (e2d_ready || cmd_active) begin
            // Drained by execute or emptied by a command
            state_nxt = STATE_EMPTY;
        end else begin
            state_nxt = state;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= STATE_EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

    // No register reads while execute holds the stage
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == STATE_FULL && !e2d_ready) |-> (!rs1_read && !rs2_read));

    // Never read a register execute is about to write
    assert property (@(posedge clk) disable iff (!rst_n)
        (uses_rs1 && e2d_rd_write && rs1_addr == e2d_rd_waddr) |-> !rs1_read);

endmodule

// ==== verilog/decode_stage_reg.sv ====
module decode_stage_reg (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load,
    input  decode_pkg::word_t       instr,
    input  decode_pkg::word_t       pc,
    input  decode_pkg::instr_type_t instr_type,
    input  decode_pkg::alu_sel_t    alu_sel,
    input  decode_pkg::muldiv_sel_t muldiv_sel,
    input  decode_pkg::in0_sel_t    in0_sel,
    input  decode_pkg::in1_sel_t    in1_sel,
    input  decode_pkg::rd_sel_t     rd_sel,
    input  decode_pkg::shamt_sel_t  shamt_sel,
    input  logic                    illegal,
    output decode_pkg::word_t       d2e_instr,
    output decode_pkg::word_t       d2e_pc,
    output decode_pkg::instr_type_t d2e_instr_type,
    output decode_pkg::alu_sel_t    d2e_alu_sel,
    output decode_pkg::muldiv_sel_t d2e_muldiv_sel,
    output decode_pkg::in0_sel_t    d2e_in0_sel,
    output decode_pkg::in1_sel_t    d2e_in1_sel,
    output decode_pkg::rd_sel_t     d2e_rd_sel,
    output decode_pkg::shamt_sel_t  d2e_shamt_sel,
    output logic                    d2e_instr_illegal
);
    import decode_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Same values the classifier gives by default
            d2e_instr         <= '0;
            d2e_pc            <= '0;
            d2e_instr_type    <= TYPE_NOP;
            d2e_alu_sel       <= ALU_ADD;
            d2e_muldiv_sel    <= MD_MUL;
            d2e_in0_sel       <= IN0_RS1;
            d2e_in1_sel       <= IN1_RS2;
            d2e_rd_sel        <= RD_ALU;
            d2e_shamt_sel     <= SHAMT_RS2;
            d2e_instr_illegal <= 1'b0;
        end else if (load) begin
            // Raw word and pc travel along for immediates and link address
            d2e_instr         <= instr;
            d2e_pc            <= pc;
            d2e_instr_type    <= instr_type;
            d2e_alu_sel       <= alu_sel;
            d2e_muldiv_sel    <= muldiv_sel;
            d2e_in0_sel       <= in0_sel;
            d2e_in1_sel       <= in1_sel;
            d2e_rd_sel        <= rd_sel;
            d2e_shamt_sel     <= shamt_sel;
            d2e_instr_illegal <= illegal;
        end
    end

    // Execute sees a steady control word between loads
    assert property (@(posedge clk) disable iff (!rst_n)
        !load |=> $stable({d2e_instr, d2e_pc, d2e_instr_type, d2e_alu_sel,
                           d2e_muldiv_sel, d2e_in0_sel, d2e_in1_sel, d2e_rd_sel,
                           d2e_shamt_sel, d2e_instr_illegal}));

endmodule

// ==== verilog/decode_top.sv ====
`include "decode_defines.svh"

module decode_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      f2d_instr_valid,
    input  decode_pkg::word_t         f2d_instr,
    input  decode_pkg::word_t         f2d_pc,
    input  logic                      e2d_ready,
    input  decode_pkg::pipeline_cmd_t e2d_cmd,
    input  decode_pkg::word_t         e2d_jump_target,
    input  logic                      e2d_rd_write,
    input  decode_pkg::reg_addr_t     e2d_rd_waddr,
    output logic                      d2f_ready,
    output decode_pkg::pipeline_cmd_t d2f_cmd,
    output decode_pkg::word_t         d2f_jump_target,
    output logic                      d2e_instr_valid,
    output decode_pkg::word_t         d2e_instr,
    output decode_pkg::word_t         d2e_pc,
    output decode_pkg::instr_type_t   d2e_instr_type,
    output decode_pkg::alu_sel_t      d2e_alu_sel,
    output decode_pkg::muldiv_sel_t   d2e_muldiv_sel,
    output decode_pkg::in0_sel_t      d2e_in0_sel,
    output decode_pkg::in1_sel_t      d2e_in1_sel,
    output decode_pkg::rd_sel_t       d2e_rd_sel,
    output decode_pkg::shamt_sel_t    d2e_shamt_sel,
    output logic                      d2e_instr_illegal,
    output logic                      rs1_read,
    output decode_pkg::reg_addr_t     rs1_addr,
    output logic                      rs2_read,
    output decode_pkg::reg_addr_t     rs2_addr
);
    import decode_pkg::*;

    // Combinational decode of the word presented by fetch
    instr_type_t instr_type;
    alu_sel_t    alu_sel;
    muldiv_sel_t muldiv_sel;
    in0_sel_t    in0_sel;
    in1_sel_t    in1_sel;
    rd_sel_t     rd_sel;
    shamt_sel_t  shamt_sel;
    logic        illegal;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        load;

    // Source fields, regardless of format
    assign rs1_addr = f2d_instr[15 +: `REG_ADDR_W];
    assign rs2_addr = f2d_instr[20 +: `REG_ADDR_W];

    // Commands from execute go straight back to fetch
    assign d2f_cmd         = e2d_cmd;
    assign d2f_jump_target = e2d_jump_target;

    decode_classify u_classify (
        .instr(f2d_instr), .instr_type(instr_type), .alu_sel(alu_sel),
        .muldiv_sel(muldiv_sel), .in0_sel(in0_sel), .in1_sel(in1_sel),
        .rd_sel(rd_sel), .shamt_sel(shamt_sel), .illegal(illegal),
        .uses_rs1(uses_rs1), .uses_rs2(uses_rs2)
    );

    decode_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .f2d_instr_valid(f2d_instr_valid),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .uses_rs1(uses_rs1), .uses_rs2(uses_rs2),
        .e2d_ready(e2d_ready), .e2d_cmd(e2d_cmd),
        .e2d_rd_write(e2d_rd_write), .e2d_rd_waddr(e2d_rd_waddr),
        .load(load), .d2e_instr_valid(d2e_instr_valid), .d2f_ready(d2f_ready),
        .rs1_read(rs1_read), .rs2_read(rs2_read)
    );

    decode_stage_reg u_stage_reg (
        .clk(clk), .rst_n(rst_n), .load(load),
        .instr(f2d_instr), .pc(f2d_pc), .instr_type(instr_type),
        .alu_sel(alu_sel), .muldiv_sel(muldiv_sel), .in0_sel(in0_sel),
        .in1_sel(in1_sel), .rd_sel(rd_sel), .shamt_sel(shamt_sel), .illegal(illegal),
        .d2e_instr(d2e_instr), .d2e_pc(d2e_pc), .d2e_instr_type(d2e_instr_type),
        .d2e_alu_sel(d2e_alu_sel), .d2e_muldiv_sel(d2e_muldiv_sel),
        .d2e_in0_sel(d2e_in0_sel), .d2e_in1_sel(d2e_in1_sel),
        .d2e_rd_sel(d2e_rd_sel), .d2e_shamt_sel(d2e_shamt_sel),
        .d2e_instr_illegal(d2e_instr_illegal)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Low over the first two rising edges and released just after the second
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

// ==== tb/tb_decode.sv ====
`include "decode_defines.svh"

module tb_decode;
    timeunit 1ns;
    timeprecision 1ps;
    import decode_pkg::*;

    localparam int NUM_INSTR      = 400;
    localparam int RESET_TIMEOUT  = 10;
    localparam int ACCEPT_TIMEOUT = 64;
    localparam int DRAIN_TIMEOUT  = 16;

    // ALU operation by funct3 before the SUB/SRA override
    localparam alu_sel_t ALU_BY_F3 [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                          ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    localparam muldiv_sel_t MD_BY_F3 [8] = '{MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU,
                                            MD_DIV, MD_DIVU, MD_REM, MD_REMU};
    // Kept classes followed by SYSTEM, FENCE and AMO
    localparam logic [6:0] OPCODES [13] = '{`OPC_OP, `OPC_OP, `OPC_OP_IMM, `OPC_LUI,
        `OPC_AUIPC, `OPC_JAL, `OPC_JALR, `OPC_BRANCH, `OPC_LOAD, `OPC_STORE,
        7'b1110011, 7'b0001111, 7'b0101111};
    localparam logic [6:0] F7_CHOICES [4] = '{`F7_BASE, `F7_ALT, `F7_MULDIV, `F7_BASE};

    typedef struct packed {
        instr_type_t instr_type;
        alu_sel_t    alu_sel;
        muldiv_sel_t muldiv_sel;
        in0_sel_t    in0_sel;
        in1_sel_t    in1_sel;
        rd_sel_t     rd_sel;
        shamt_sel_t  shamt_sel;
        logic        illegal;
    } ctrl_t;

    typedef struct packed {
        ctrl_t ctrl;
        logic  use1;
        logic  use2;
    } ref_t;

    logic          clk;
    logic          rst_n;
    logic          f2d_instr_valid;
    word_t         f2d_instr;
    word_t         f2d_pc;
    logic          e2d_ready;
    pipeline_cmd_t e2d_cmd;
    word_t         e2d_jump_target;
    logic          e2d_rd_write;
    reg_addr_t     e2d_rd_waddr;
    logic          d2f_ready;
    pipeline_cmd_t d2f_cmd;
    word_t         d2f_jump_target;
    logic          d2e_instr_valid;
    word_t         d2e_instr;
    word_t         d2e_pc;
    instr_type_t   d2e_instr_type;
    alu_sel_t      d2e_alu_sel;
    muldiv_sel_t   d2e_muldiv_sel;
    in0_sel_t      d2e_in0_sel;
    in1_sel_t      d2e_in1_sel;
    rd_sel_t       d2e_rd_sel;
    shamt_sel_t    d2e_shamt_sel;
    logic          d2e_instr_illegal;
    logic          rs1_read;
    reg_addr_t     rs1_addr;
    logic          rs2_read;
    reg_addr_t     rs2_addr;

    // Reference model state
    ref_t   cur;
    ctrl_t  act_ctrl;
    ctrl_t  exp_ctrl;
    word_t  exp_instr;
    word_t  exp_pc;
    logic   exp_full;
    logic   exp_load;
    logic   stale1;
    logic   stale2;
    logic   cmd_active;
    logic   accepted_q;
    logic   timed_out;
    integer seed;
    int     errors;
    int     loads;
    int     holds;
    int     hazards;
    int     commands;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_top DUT (.*);

    function automatic ref_t reference_decode(word_t w);
        ref_t       r;
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       shift;
        op = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        shift = (f3 == 3'b001 || f3 == 3'b101);
        // Every default is the first enum member
        r = '0;
        r.ctrl.illegal = 1'b1;
        case (op)
            `OPC_OP: begin
                if (f7 == `F7_MULDIV) begin
                    r.ctrl = '{TYPE_MULDIV, ALU_ADD, MD_BY_F3[f3], IN0_RS1, IN1_RS2,
                               RD_MULDIV, SHAMT_RS2, 1'b0};
                end else if (f7 == `F7_BASE || (f7 == `F7_ALT && f3 == 3'b000)) begin
                    r.ctrl = '{TYPE_ALU, (f7 == `F7_ALT) ? ALU_SUB : ALU_BY_F3[f3], MD_MUL,
                               IN0_RS1, IN1_RS2, RD_ALU, SHAMT_RS2, 1'b0};
                end else if (f7 == `F7_ALT && f3 == 3'b101) begin
                    r.ctrl = '{TYPE_ALU, ALU_SRA, MD_MUL, IN0_RS1, IN1_RS2, RD_ALU,
                               SHAMT_RS2, 1'b0};
                end
                r.use1 = !r.ctrl.illegal;
                r.use2 = !r.ctrl.illegal;
            end
            `OPC_OP_IMM: begin
                // Shift immediates need a clean funct7 except SRAI with its alternate form
                if (!shift || f7 == `F7_BASE || (f3 == 3'b101 && f7 == `F7_ALT)) begin
                    r.ctrl = '{TYPE_ALU, (shift && f7 == `F7_ALT) ? ALU_SRA : ALU_BY_F3[f3],
                               MD_MUL, IN0_RS1, IN1_SIMM12, RD_ALU, SHAMT_IMM, 1'b0};
                    r.use1 = 1'b1;
                end
            end
            `OPC_LUI:
                r.ctrl = '{TYPE_ALU, ALU_ADD, MD_MUL, IN0_RS1, IN1_RS2, RD_LUI, SHAMT_RS2, 1'b0};
            `OPC_AUIPC:
                r.ctrl = '{TYPE_ALU, ALU_ADD, MD_MUL, IN0_PC, IN1_IMM_UPPER, RD_ALU,
                           SHAMT_RS2, 1'b0};
            `OPC_JAL:
                r.ctrl = '{TYPE_JUMP, ALU_ADD, MD_MUL, IN0_PC, IN1_JAL_OFFSET, RD_ALU,
                           SHAMT_RS2, 1'b0};
            `OPC_JALR: begin
                if (f3 == 3'b000) begin
                    r.ctrl = '{TYPE_JUMP, ALU_ADD, MD_MUL, IN0_RS1, IN1_SIMM12, RD_ALU,
                               SHAMT_RS2, 1'b0};
                    r.use1 = 1'b1;
                end
            end
            `OPC_BRANCH: begin
                r.ctrl = '{TYPE_BRANCH, ALU_ADD, MD_MUL, IN0_PC, IN1_BRANCH_OFFSET, RD_ALU,
                           SHAMT_RS2, 1'b0};
                r.use1 = 1'b1;
                r.use2 = 1'b1;
            end
            `OPC_LOAD: begin
                r.ctrl = '{TYPE_LOAD, ALU_ADD, MD_MUL, IN0_RS1, IN1_SIMM12, RD_MEMORY,
                           SHAMT_RS2, 1'b0};
                r.use1 = 1'b1;
            end
            `OPC_STORE: begin
                // SB, SH and SW only
                if (!f3[2]) begin
                    r.ctrl = '{TYPE_STORE, ALU_ADD, MD_MUL, IN0_RS1, IN1_STORE_IMM, RD_ALU,
                               SHAMT_RS2, 1'b0};
                    r.use1 = 1'b1;
                    r.use2 = 1'b1;
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    function automatic word_t random_instr();
        word_t w;
        word_t r;
        w = $random(seed);
        r = $random(seed);
        // Three in sixteen stay fully random words
        if (r[3:0] < 4'd13) begin
            w[6:0] = OPCODES[r[3:0]];
            if (w[6:0] == `OPC_OP || w[6:0] == `OPC_OP_IMM)
                w[31:25] = F7_CHOICES[r[5:4]];
            if (w[6:0] == `OPC_JALR && r[6])
                w[14:12] = 3'b000;
        end
        return w;
    endfunction

    // Random ready, rare commands, writes aimed at the current sources
    task automatic drive_execute(word_t w);
        logic [31:0] sel;
        sel = $random(seed);
        e2d_ready = (sel[7:0] < 8'd150);
        e2d_cmd   = CMD_NONE;
        if (sel[15:8] < 8'd16) begin
            e2d_ready       = 1'b1;
            e2d_cmd         = (sel[17:16] == 2'd0) ? CMD_BRANCH : pipeline_cmd_t'(sel[17:16]);
            e2d_jump_target = $random(seed);
        end
        sel = $random(seed);
        e2d_rd_write = sel[0];
        case (sel[2:1])
            2'd0:    e2d_rd_waddr = w[19:15];
            2'd1:    e2d_rd_waddr = w[24:20];
            default: e2d_rd_waddr = sel[7:3];
        endcase
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        errors++;
        $display("ERROR t=%0t signal=%s expected=%0h actual=%0h", $time, name, expected, actual);
    endtask

    task automatic report_ctrl(ctrl_t expected, ctrl_t actual);
        if (expected.instr_type !== actual.instr_type)
            report_mismatch("d2e_instr_type", expected.instr_type, actual.instr_type);
        if (expected.alu_sel !== actual.alu_sel)
            report_mismatch("d2e_alu_sel", expected.alu_sel, actual.alu_sel);
        if (expected.muldiv_sel !== actual.muldiv_sel)
            report_mismatch("d2e_muldiv_sel", expected.muldiv_sel, actual.muldiv_sel);
        if (expected.in0_sel !== actual.in0_sel)
            report_mismatch("d2e_in0_sel", expected.in0_sel, actual.in0_sel);
        if (expected.in1_sel !== actual.in1_sel)
            report_mismatch("d2e_in1_sel", expected.in1_sel, actual.in1_sel);
        if (expected.rd_sel !== actual.rd_sel)
            report_mismatch("d2e_rd_sel", expected.rd_sel, actual.rd_sel);
        if (expected.shamt_sel !== actual.shamt_sel)
            report_mismatch("d2e_shamt_sel", expected.shamt_sel, actual.shamt_sel);
        if (expected.illegal !== actual.illegal)
            report_mismatch("d2e_instr_illegal", expected.illegal, actual.illegal);
    endtask

    assign cur        = reference_decode(f2d_instr);
    assign cmd_active = (e2d_cmd != CMD_NONE);
    assign stale1     = cur.use1 && e2d_rd_write && (f2d_instr[19:15] == e2d_rd_waddr);
    assign stale2     = cur.use2 && e2d_rd_write && (f2d_instr[24:20] == e2d_rd_waddr);
    assign exp_load   = f2d_instr_valid && !cmd_active && !stale1 && !stale2 &&
                        (!exp_full || e2d_ready);
    assign act_ctrl   = '{d2e_instr_type, d2e_alu_sel, d2e_muldiv_sel, d2e_in0_sel,
                          d2e_in1_sel, d2e_rd_sel, d2e_shamt_sel, d2e_instr_illegal};

    // Occupancy model and the word execute should be holding
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_full   <= 1'b0;
            accepted_q <= 1'b0;
        end else begin
            accepted_q <= f2d_instr_valid && d2f_ready;
            if (exp_load) begin
                exp_full  <= 1'b1;
                exp_instr <= f2d_instr;
                exp_pc    <= f2d_pc;
                exp_ctrl  <= cur.ctrl;
                loads++;
            end else if (e2d_ready || cmd_active) begin
                exp_full <= 1'b0;
            end
            if (exp_full && !e2d_ready && !cmd_active)
                holds++;
            if (f2d_instr_valid && !cmd_active && (stale1 || stale2))
                hazards++;
            if (cmd_active)
                commands++;
        end
    end

    // Valid low after reset, set by a load, cleared by drain or command
    assert property (@(posedge clk) disable iff (!rst_n) d2e_instr_valid == exp_full)
        else report_mismatch("d2e_instr_valid", $sampled(exp_full), $sampled(d2e_instr_valid));

    // While full, the outputs are the last loaded word, so a hold keeps them
    assert property (@(posedge clk) disable iff (!rst_n) d2e_instr_valid |-> d2e_instr == exp_instr)
        else report_mismatch("d2e_instr", $sampled(exp_instr), $sampled(d2e_instr));
    assert property (@(posedge clk) disable iff (!rst_n) d2e_instr_valid |-> d2e_pc == exp_pc)
        else report_mismatch("d2e_pc", $sampled(exp_pc), $sampled(d2e_pc));
    assert property (@(posedge clk) disable iff (!rst_n) d2e_instr_valid |-> act_ctrl == exp_ctrl)
        else report_ctrl($sampled(exp_ctrl), $sampled(act_ctrl));

    // Back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        (d2e_instr_valid && !e2d_ready && !cmd_active) |-> !(d2f_ready || rs1_read || rs2_read))
        else report_mismatch("{d2f_ready,rs1_read,rs2_read}", 0,
                             {$sampled(d2f_ready), $sampled(rs1_read), $sampled(rs2_read)});

    // Hazard stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        (stale1 && !cmd_active) |-> !(d2f_ready || rs1_read))
        else report_mismatch("{d2f_ready,rs1_read}", 0, {$sampled(d2f_ready), $sampled(rs1_read)});
    assert property (@(posedge clk) disable iff (!rst_n)
        (stale2 && !cmd_active) |-> !(d2f_ready || rs2_read))
        else report_mismatch("{d2f_ready,rs2_read}", 0, {$sampled(d2f_ready), $sampled(rs2_read)});

    // Command passthrough and emptying
    assert property (@(posedge clk) disable iff (!rst_n) d2f_cmd == e2d_cmd)
        else report_mismatch("d2f_cmd", $sampled(e2d_cmd), $sampled(d2f_cmd));
    assert property (@(posedge clk) disable iff (!rst_n) d2f_jump_target == e2d_jump_target)
        else report_mismatch("d2f_jump_target", $sampled(e2d_jump_target),
                             $sampled(d2f_jump_target));
    assert property (@(posedge clk) disable iff (!rst_n) cmd_active |=> !d2e_instr_valid)
        else report_mismatch("d2e_instr_valid", 0, 1);

    // Ready from the load rule or forced by a command
    assert property (@(posedge clk) disable iff (!rst_n) d2f_ready == (exp_load || cmd_active))
        else report_mismatch("d2f_ready", $sampled(exp_load || cmd_active), $sampled(d2f_ready));

    // Register file port
    assert property (@(posedge clk) disable iff (!rst_n) rs1_addr == f2d_instr[19:15])
        else report_mismatch("rs1_addr", $sampled(f2d_instr[19:15]), $sampled(rs1_addr));
    assert property (@(posedge clk) disable iff (!rst_n) rs2_addr == f2d_instr[24:20])
        else report_mismatch("rs2_addr", $sampled(f2d_instr[24:20]), $sampled(rs2_addr));
    assert property (@(posedge clk) disable iff (!rst_n)
        rs1_read == (d2f_ready && !cmd_active && cur.use1))
        else report_mismatch("rs1_read", $sampled(d2f_ready && !cmd_active && cur.use1),
                             $sampled(rs1_read));
    assert property (@(posedge clk) disable iff (!rst_n)
        rs2_read == (d2f_ready && !cmd_active && cur.use2))
        else report_mismatch("rs2_read", $sampled(d2f_ready && !cmd_active && cur.use2),
                             $sampled(rs2_read));

    initial begin
        int          n;
        int          wait_cycles;
        logic [31:0] gap;
        seed            = 32'hd55bb206;
        errors          = 0;
        loads           = 0;
        holds           = 0;
        hazards         = 0;
        commands        = 0;
        timed_out       = 1'b0;
        f2d_instr_valid = 1'b0;
        f2d_instr       = '0;
        f2d_pc          = '0;
        e2d_ready       = 1'b0;
        e2d_cmd         = CMD_NONE;
        e2d_jump_target = '0;
        e2d_rd_write    = 1'b0;
        e2d_rd_waddr    = '0;

        // Reset release checked on the rising edge
        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
            timed_out = 1'b1;
        end
        #2;

        for (n = 0; n < NUM_INSTR && !timed_out; n++) begin
            // Idle slot now and then so the stage can drain
            gap = $random(seed);
            if (gap[1:0] == 2'd0) begin
                f2d_instr_valid = 1'b0;
                f2d_instr       = $random(seed);
                drive_execute(f2d_instr);
                next_cycle();
            end
            f2d_instr_valid = 1'b1;
            f2d_instr       = random_instr();
            f2d_pc          = $random(seed) & 32'hffff_fffc;
            // Fetch holds the word until the handshake
            wait_cycles = 0;
            do begin
                drive_execute(f2d_instr);
                next_cycle();
                wait_cycles++;
            end while (!accepted_q && wait_cycles < ACCEPT_TIMEOUT);
            if (!accepted_q) begin
                $display("Instruction %h was not taken within %0d cycles", f2d_instr,
                         ACCEPT_TIMEOUT);
                timed_out = 1'b1;
            end
        end

        // Let execute take the last one
        f2d_instr_valid = 1'b0;
        e2d_ready       = 1'b1;
        e2d_cmd         = CMD_NONE;
        e2d_rd_write    = 1'b0;
        wait_cycles     = 0;
        do begin
            next_cycle();
            wait_cycles++;
        end while (d2e_instr_valid && wait_cycles < DRAIN_TIMEOUT);
        if (d2e_instr_valid) begin
            $display("Decode stage did not drain within %0d cycles", DRAIN_TIMEOUT);
            timed_out = 1'b1;
        end

        $display("Summary: loads=%0d holds=%0d hazards=%0d commands=%0d errors=%0d timeout=%0d",
                 loads, holds, hazards, commands, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/decode_pkg.sv
verilog/decode_classify.sv
verilog/decode_ctrl.sv
verilog/decode_stage_reg.sv
verilog/decode_top.sv
tb/tb_clock_gen.sv
tb/tb_decode.sv
